// File: logic/colmix_pkg.sv
// colour mixer shared types

package colmix_pkg;

    // character layer pixel
    typedef struct packed {
        logic       prio;
        logic [1:0] pal;
        logic [3:0] color;
    } char_pxl_t;

    // scroll layer pixel
    typedef struct packed {
        logic       prio;
        logic [5:0] pal;
        logic [3:0] color;
    } scr_pxl_t;

    // object pixel
    // pal of all ones marks a shadow object
    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] color;
    } obj_pxl_t;

    // merged layer entry
    // low 11 bits form the palette address
    typedef struct packed {
        logic       shadow;
        logic       is_obj;
        logic [5:0] pal;
        logic [3:0] color;
    } lyr_t;

    typedef logic [10:0] pal_addr_t;

    // cpu side of the palette
    // dsn is active low with one bit per byte
    typedef struct packed {
        logic        cs;
        logic [10:0] addr;
        logic [15:0] dout;
        logic [1:0]  dsn;
    } cpu_bus_t;

    // 5 bits per channel
    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    // palette word layout
    // four msbs per channel in the low 12 bits and lsbs in bits 14..12
    function automatic rgb_t unpack_color(input logic [15:0] word);
        rgb_t c;
        c.red   = {word[3:0], word[12]};
        c.green = {word[7:4], word[13]};
        c.blue  = {word[11:8], word[14]};
        return c;
    endfunction

    // shadow dimming to roughly three quarters brightness
    function automatic logic [4:0] dim(input logic [4:0] a);
        return a - (a >> 2);
    endfunction

endpackage

// File: logic/layer_mux.sv
// layer gating and priority

`timescale 1ns/1ps

module layer_mux (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  logic [3:0]            gfx_en,
    input  colmix_pkg::char_pxl_t char_pxl,
    input  colmix_pkg::scr_pxl_t  scr1_pxl,
    input  colmix_pkg::scr_pxl_t  scr2_pxl,
    input  colmix_pkg::obj_pxl_t  obj_pxl,
    output colmix_pkg::pal_addr_t pal_addr,
    output logic                  shadow
);

    // gated layer pixels
    colmix_pkg::char_pxl_t char_g;
    colmix_pkg::scr_pxl_t  scr1_g;
    colmix_pkg::scr_pxl_t  scr2_g;
    colmix_pkg::obj_pxl_t  obj_g;

    // tile entries before the object merge
    colmix_pkg::lyr_t char_t;
    colmix_pkg::lyr_t scr1_t;
    colmix_pkg::lyr_t scr2_t;
    colmix_pkg::lyr_t back_t;

    // per pixel registers for char, scr1, scr2 and backdrop
    colmix_pkg::lyr_t lyr [4];

    // object replaces the tile when it is visible, has enough priority
    // and the tile is either low priority or transparent
    function automatic colmix_pkg::lyr_t tile_or_obj(
        input colmix_pkg::obj_pxl_t obj,
        input colmix_pkg::lyr_t     tile,
        input logic                 tile_prio,
        input logic                 prio_ok
    );
        colmix_pkg::lyr_t res;
        logic             take;
        take = (obj.color != 4'd0) && prio_ok &&
               (!tile_prio || tile.color[2:0] == 3'd0);
        res = tile;
        if (take) begin
            if (&obj.pal) begin
                // shadow object keeps the tile and only marks it
                res.shadow = 1'b1;
            end else begin
                res.is_obj = 1'b1;
                res.pal    = obj.pal;
                res.color  = obj.color;
            end
        end
        return res;
    endfunction

    // objects use all four colour bits and tiles only the low three
    function automatic logic opaque(input colmix_pkg::lyr_t l);
        return l.is_obj ? (l.color != 4'd0) : (l.color[2:0] != 3'd0);
    endfunction

    // debug enables clear the colour index
    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[0]) char_g.color = 4'd0;
        if (!gfx_en[1]) scr1_g.color = 4'd0;
        if (!gfx_en[2]) scr2_g.color = 4'd0;
        if (!gfx_en[3]) obj_g.color  = 4'd0;
    end

    always_comb begin
        // char palette sits in the low part of the tile range
        char_t = '{shadow: 1'b0, is_obj: 1'b0, pal: {4'd0, char_g.pal}, color: char_g.color};
        scr1_t = '{shadow: 1'b0, is_obj: 1'b0, pal: scr1_g.pal, color: scr1_g.color};
        scr2_t = '{shadow: 1'b0, is_obj: 1'b0, pal: scr2_g.pal, color: scr2_g.color};
        // backdrop uses the scr2 palette with no colour
        back_t = '{shadow: 1'b0, is_obj: 1'b0, pal: scr2_g.pal, color: 4'd0};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                lyr[i] <= '0;
            end
        end else if (pxl_cen) begin
            // object needs 3 over char, 2 or more over scr1 and 1 or more over scr2
            lyr[0] <= tile_or_obj(obj_g, char_t, char_g.prio, obj_g.prio == 2'd3);
            lyr[1] <= tile_or_obj(obj_g, scr1_t, scr1_g.prio, obj_g.prio >= 2'd2);
            lyr[2] <= tile_or_obj(obj_g, scr2_t, scr2_g.prio, obj_g.prio >= 2'd1);
            // backdrop always loses to a visible object
            lyr[3] <= tile_or_obj(obj_g, back_t, 1'b0, 1'b1);
        end
    end

    // first opaque entry wins, backdrop otherwise
    always_comb begin
        if (opaque(lyr[0])) begin
            pal_addr = lyr[0][10:0];
        end else if (opaque(lyr[1])) begin
            pal_addr = lyr[1][10:0];
        end else if (opaque(lyr[2])) begin
            pal_addr = lyr[2][10:0];
        end else begin
            pal_addr = lyr[3][10:0];
        end
        shadow = lyr[0].shadow | lyr[1].shadow | lyr[2].shadow | lyr[3].shadow;
    end

    // registers come out of reset clean and stay defined
    a_addr_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(pal_addr)
    );

endmodule

// File: logic/palette_ram.sv
// dual port palette memory

`timescale 1ns/1ps

module palette_ram (
    input  logic                  clk,
    input  colmix_pkg::cpu_bus_t  cpu,
    input  colmix_pkg::pal_addr_t pal_addr,
    output logic [15:0]           cpu_din,
    output logic [15:0]           pal_word
);

    // byte write enables
    logic [1:0] we;

    assign we = ~cpu.dsn & {2{cpu.cs}};

    // one 2048 x 8 memory per byte lane
    for (genvar lane = 0; lane < 2; lane++) begin : g_lane
        logic [7:0] mem [0:2047];
        logic [7:0] cpu_q;
        logic [7:0] vid_q;

        // cpu port
        // read returns the old contents on a write
        always_ff @(posedge clk) begin
            if (we[lane]) begin
                mem[cpu.addr] <= cpu.dout[lane*8 +: 8];
            end
            cpu_q <= mem[cpu.addr];
        end

        // read only video port
        always_ff @(posedge clk) begin
            vid_q <= mem[pal_addr];
        end
    end

    // lanes back into words
    assign cpu_din  = {g_lane[1].cpu_q, g_lane[0].cpu_q};
    assign pal_word = {g_lane[1].vid_q, g_lane[0].vid_q};

    // no write without chip select
    // with cs low and the address held, the readback must not move
    a_no_write_idle: assert property (
        @(posedge clk)
        (!$past(cpu.cs) && cpu.addr == $past(cpu.addr))
            |=> ($isunknown($past(cpu_din)) || $stable(cpu_din))
    );

endmodule

// File: logic/shade_blank.sv
// shadow, video enable and blanking

`timescale 1ns/1ps

module shade_blank #(
    parameter int BLANK_DLY = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  logic               video_en,
    input  logic               shadow,
    input  logic               lhbl,
    input  logic               lvbl,
    input  logic [15:0]        pal_word,
    output colmix_pkg::rgb_t   rgb,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);

    // unpacked and processed colour
    colmix_pkg::rgb_t raw;
    colmix_pkg::rgb_t shaded;
    colmix_pkg::rgb_t gated;

    // stage 0 samples and stages 1..BLANK_DLY delay
    colmix_pkg::rgb_t     rgb_dl  [0:BLANK_DLY];
    logic [BLANK_DLY:0]   lhbl_dl;
    logic [BLANK_DLY:0]   lvbl_dl;

    assign raw = colmix_pkg::unpack_color(pal_word);

    // bit 15 exempts the entry from shadow
    always_comb begin
        shaded = raw;
        if (shadow && !pal_word[15]) begin
            shaded.red   = colmix_pkg::dim(raw.red);
            shaded.green = colmix_pkg::dim(raw.green);
            shaded.blue  = colmix_pkg::dim(raw.blue);
        end
    end

    // video off or either blank gives black
    // the blanked colour travels with its flags through the delay line
    assign gated = (video_en && lhbl && lvbl) ? shaded : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i <= BLANK_DLY; i++) begin
                rgb_dl[i] <= '0;
            end
            lhbl_dl <= '0;
            lvbl_dl <= '0;
        end else if (pxl_cen) begin
            // sample stage
            rgb_dl[0]  <= gated;
            lhbl_dl[0] <= lhbl;
            lvbl_dl[0] <= lvbl;
            // shift the rest along
            for (int i = 1; i <= BLANK_DLY; i++) begin
                rgb_dl[i]  <= rgb_dl[i-1];
                lhbl_dl[i] <= lhbl_dl[i-1];
                lvbl_dl[i] <= lvbl_dl[i-1];
            end
        end
    end

    assign lhbl_dly = lhbl_dl[BLANK_DLY];
    assign lvbl_dly = lvbl_dl[BLANK_DLY];

    // last stage of the colour line
    assign rgb = rgb_dl[BLANK_DLY];

    // nothing visible leaks into the blanking intervals
    a_black_in_blank: assert property (
        @(posedge clk) (!lhbl_dly || !lvbl_dly) |-> (rgb == '0)
    );

endmodule

// File: logic/colmix_top.sv
// colour mixer top level

`timescale 1ns/1ps

module colmix_top #(
    parameter int BLANK_DLY = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  logic                  video_en,
    input  logic                  lhbl,
    input  logic                  lvbl,
    input  logic [3:0]            gfx_en,
    // palette access from the cpu
    input  colmix_pkg::cpu_bus_t  cpu,
    output logic [15:0]           cpu_din,
    // layer pixels
    input  colmix_pkg::char_pxl_t char_pxl,
    input  colmix_pkg::scr_pxl_t  scr1_pxl,
    input  colmix_pkg::scr_pxl_t  scr2_pxl,
    input  colmix_pkg::obj_pxl_t  obj_pxl,
    // video out
    output colmix_pkg::rgb_t      rgb,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly
);

    // layer_mux to palette
    colmix_pkg::pal_addr_t pal_addr;
    logic                  shadow;

    // palette to shade_blank
    logic [15:0] pal_word;
    logic        shadow_q;

    // priority resolve registered per pixel
    layer_mux layer_mux_i (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr),
        .shadow   (shadow)
    );

    // colour lookup
    // video word lands one clock after the address
    palette_ram palette_ram_i (
        .clk      (clk),
        .cpu      (cpu),
        .pal_addr (pal_addr),
        .cpu_din  (cpu_din),
        .pal_word (pal_word)
    );

    // shadow follows the ram read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            shadow_q <= 1'b0;
        end else begin
            shadow_q <= shadow;
        end
    end

    // dimming, video enable, blank delay
    shade_blank #(
        .BLANK_DLY (BLANK_DLY)
    ) shade_blank_i (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .video_en (video_en),
        .shadow   (shadow_q),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pal_word (pal_word),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

// File: verification/tb_colmix.sv
// colour mixer testbench

`timescale 1ns/1ps

module tb_colmix;

    localparam int BLANK_DLY   = 2;
    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = NUM_TESTS * 3000;

    logic                  clk;
    logic                  reset;
    logic                  pxl_cen;
    logic                  video_en;
    logic                  lhbl;
    logic                  lvbl;
    logic [3:0]            gfx_en;
    colmix_pkg::cpu_bus_t  cpu;
    logic [15:0]           cpu_din;
    colmix_pkg::char_pxl_t char_pxl;
    colmix_pkg::scr_pxl_t  scr1_pxl;
    colmix_pkg::scr_pxl_t  scr2_pxl;
    colmix_pkg::obj_pxl_t  obj_pxl;
    colmix_pkg::rgb_t      rgb;
    logic                  lhbl_dly;
    logic                  lvbl_dly;

    // reference copy of the palette
    logic [15:0] model [0:2047];

    integer     seed    = 32'h424d;
    int         errors  = 0;
    int         checks  = 0;
    int         cycles  = 0;
    logic [1:0] cen_cnt = 2'd0;
    string      test_name = "";

    colmix_top #(
        .BLANK_DLY (BLANK_DLY)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .video_en (video_en),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .gfx_en   (gfx_en),
        .cpu      (cpu),
        .cpu_din  (cpu_din),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    always #2 clk = ~clk;

    // strobe on every fourth clock
    always @(posedge clk) begin
        #1;
        cen_cnt = cen_cnt + 2'd1;
        pxl_cen = (cen_cnt == 2'd3);
    end

    // run limit
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_rgb(input colmix_pkg::rgb_t want, input colmix_pkg::rgb_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error: %s expected %h actual %h", test_name, want, got);
        end
    endtask

    task automatic check_word(input logic [15:0] want, input logic [15:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error: %s expected %h actual %h", test_name, want, got);
        end
    endtask

    task automatic check_flag(input logic want, input logic got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error: %s expected %b actual %b", test_name, want, got);
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // cpu write with the model following the byte strobes
    task automatic write_word(input colmix_pkg::pal_addr_t a, input logic [15:0] d,
                              input logic [1:0] n);
        cpu = '{cs: 1'b1, addr: a, dout: d, dsn: n};
        @(posedge clk);
        #1;
        cpu.cs = 1'b0;
        if (!n[0]) model[a][7:0] = d[7:0];
        if (!n[1]) model[a][15:8] = d[15:8];
    endtask

    // readback lands one clock after the address
    task automatic read_word(input colmix_pkg::pal_addr_t a, output logic [15:0] d);
        cpu.cs   = 1'b0;
        cpu.addr = a;
        @(posedge clk);
        #1;
        d = cpu_din;
    endtask

    task automatic wait_strobes(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (pxl_cen) seen++;
        end
        #1;
    endtask

    // expected palette address and shadow for one pixel
    task automatic resolve_pixel(input colmix_pkg::char_pxl_t c, input colmix_pkg::scr_pxl_t s1,
                                 input colmix_pkg::scr_pxl_t s2, input colmix_pkg::obj_pxl_t o,
                                 input logic [3:0] en, output colmix_pkg::pal_addr_t addr,
                                 output logic shd);
        logic [10:0] tile_addr [4];
        logic [3:0]  tile_hi;
        logic [3:0]  tile_see;
        logic [3:0]  obj_ok;
        logic [3:0]  cc;
        logic [3:0]  c1;
        logic [3:0]  c2;
        logic [3:0]  oc;
        logic        use_obj;
        logic        found;
        cc = en[0] ? c.color : 4'd0;
        c1 = en[1] ? s1.color : 4'd0;
        c2 = en[2] ? s2.color : 4'd0;
        oc = en[3] ? o.color : 4'd0;
        // levels 0..3 are char, scroll 1, scroll 2, backdrop
        tile_addr[0] = {5'd0, c.pal, cc};
        tile_addr[1] = {1'b0, s1.pal, c1};
        tile_addr[2] = {1'b0, s2.pal, c2};
        tile_addr[3] = {1'b0, s2.pal, 4'd0};
        tile_hi  = {1'b0, s2.prio, s1.prio, c.prio};
        tile_see = {1'b0, c2[2:0] != 3'd0, c1[2:0] != 3'd0, cc[2:0] != 3'd0};
        obj_ok   = {1'b1, o.prio >= 2'd1, o.prio >= 2'd2, o.prio == 2'd3};
        addr  = tile_addr[3];
        shd   = 1'b0;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            use_obj = (oc != 4'd0) && obj_ok[i] && (!tile_hi[i] || !tile_see[i]);
            // shadow objects only mark the tile below
            if (use_obj && (&o.pal)) shd = 1'b1;
            if (!found && use_obj && !(&o.pal)) begin
                addr  = {1'b1, o.pal, oc};
                found = 1'b1;
            end else if (!found && tile_see[i]) begin
                addr  = tile_addr[i];
                found = 1'b1;
            end
        end
    endtask

    // 5 bit channels with lsbs in bits 14..12 and bit 15 exempt from shadow
    function automatic colmix_pkg::rgb_t expect_color(input logic [15:0] w, input logic shd);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = {w[3:0], w[12]};
        g = {w[7:4], w[13]};
        b = {w[11:8], w[14]};
        if (shd && !w[15]) begin
            r = r - {2'b00, r[4:2]};
            g = g - {2'b00, g[4:2]};
            b = b - {2'b00, b[4:2]};
        end
        return '{red: r, green: g, blue: b};
    endfunction

    // hold one pixel until it has crossed the pipeline, then compare
    task automatic run_pixel(input colmix_pkg::char_pxl_t c, input colmix_pkg::scr_pxl_t s1,
                             input colmix_pkg::scr_pxl_t s2, input colmix_pkg::obj_pxl_t o);
        colmix_pkg::pal_addr_t a;
        logic                  shd;
        colmix_pkg::rgb_t      want;
        char_pxl = c;
        scr1_pxl = s1;
        scr2_pxl = s2;
        obj_pxl  = o;
        wait_strobes(BLANK_DLY + 3);
        resolve_pixel(c, s1, s2, o, gfx_en, a, shd);
        want = expect_color(model[a], shd);
        if (!video_en || !lhbl || !lvbl) want = '0;
        check_rgb(want, rgb);
        check_flag(lhbl, lhbl_dly);
        check_flag(lvbl, lvbl_dly);
    endtask

    task automatic cpu_access();
        logic [31:0]           r;
        logic [15:0]           d;
        colmix_pkg::pal_addr_t a;
        test_name = "cpu fill";
        for (int i = 0; i < 2048; i++) begin
            r = next_rand();
            write_word(i[10:0], r[15:0], 2'b00);
        end
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            a = r[10:0];
            read_word(a, d);
            check_word(model[a], d);
        end
        test_name = "cpu low byte";
        write_word(11'h155, 16'hc3a5, 2'b10);
        read_word(11'h155, d);
        check_word(model[11'h155], d);
        test_name = "cpu high byte";
        write_word(11'h2aa, 16'h5a3c, 2'b01);
        read_word(11'h2aa, d);
        check_word(model[11'h2aa], d);
    endtask

    task automatic layer_priority();
        logic [31:0]           r;
        logic [31:0]           q;
        colmix_pkg::char_pxl_t c;
        colmix_pkg::scr_pxl_t  s1;
        colmix_pkg::scr_pxl_t  s2;
        colmix_pkg::obj_pxl_t  o;
        test_name = "priority";
        // all priority bits of char, both scrolls and the object at three depths
        for (int k = 0; k < 96; k++) begin
            r  = next_rand();
            q  = next_rand();
            c  = '{prio: k[0], pal: r[1:0], color: r[5:2]};
            s1 = '{prio: k[1], pal: r[11:6], color: r[15:12]};
            s2 = '{prio: k[2], pal: r[21:16], color: r[25:22]};
            o  = '{prio: k[4:3], pal: q[5:0], color: q[9:6]};
            if (c.color[2:0] == 3'd0) c.color[0] = 1'b1;
            if (s1.color[2:0] == 3'd0) s1.color[0] = 1'b1;
            if (s2.color[2:0] == 3'd0) s2.color[0] = 1'b1;
            // tiles above depth k[6:5] go transparent so lower thresholds are reached
            if (k[6:5] != 2'd0) c.color[2:0] = 3'd0;
            if (k[6:5] == 2'd2) s1.color[2:0] = 3'd0;
            if (o.color == 4'd0) o.color = 4'd1;
            if (&o.pal) o.pal[0] = 1'b0;
            run_pixel(c, s1, s2, o);
        end
    endtask

    task automatic fall_through();
        colmix_pkg::char_pxl_t c;
        colmix_pkg::scr_pxl_t  s1;
        colmix_pkg::scr_pxl_t  s2;
        colmix_pkg::obj_pxl_t  o;
        c  = '{prio: 1'b0, pal: 2'd2, color: 4'h8};
        s1 = '{prio: 1'b0, pal: 6'h11, color: 4'h6};
        s2 = '{prio: 1'b0, pal: 6'h22, color: 4'h7};
        o  = '{prio: 2'd0, pal: 6'h05, color: 4'h0};
        test_name = "char clear";
        run_pixel(c, s1, s2, o);
        test_name = "scroll 1 clear";
        s1.color = 4'h0;
        run_pixel(c, s1, s2, o);
        test_name = "backdrop";
        s2.color = 4'h8;
        run_pixel(c, s1, s2, o);
        // debug enables on fully opaque layers
        c.color  = 4'h5;
        s1.color = 4'h6;
        s2.color = 4'h7;
        test_name = "char disabled";
        gfx_en = 4'b1110;
        run_pixel(c, s1, s2, o);
        test_name = "tiles disabled";
        gfx_en  = 4'b1000;
        o.color = 4'h9;
        run_pixel(c, s1, s2, o);
        test_name = "object disabled";
        gfx_en = 4'b0111;
        o.prio = 2'd3;
        run_pixel(c, s1, s2, o);
        gfx_en = 4'hf;
    endtask

    task automatic shadow_objects();
        logic [31:0]           r;
        colmix_pkg::rgb_t      lit;
        colmix_pkg::char_pxl_t c;
        colmix_pkg::scr_pxl_t  s;
        colmix_pkg::obj_pxl_t  o;
        // low priority char at address 0x013 under a shadow object
        c = '{prio: 1'b0, pal: 2'd1, color: 4'h3};
        s = '{prio: 1'b0, pal: 6'h10, color: 4'h0};
        o = '{prio: 2'd3, pal: 6'h3f, color: 4'h5};
        test_name = "shadow dim";
        write_word(11'h013, 16'h7fff, 2'b00);
        run_pixel(c, s, s, o);
        // full scale dims to 31 - 7
        lit = '{red: 5'd24, green: 5'd24, blue: 5'd24};
        check_rgb(lit, rgb);
        test_name = "shadow exempt";
        write_word(11'h013, 16'hffff, 2'b00);
        run_pixel(c, s, s, o);
        lit = '{red: 5'd31, green: 5'd31, blue: 5'd31};
        check_rgb(lit, rgb);
        test_name = "shadow random";
        r = next_rand();
        write_word(11'h013, {1'b0, r[14:0]}, 2'b00);
        run_pixel(c, s, s, o);
    endtask

    task automatic video_enable();
        colmix_pkg::char_pxl_t c;
        colmix_pkg::scr_pxl_t  s;
        colmix_pkg::obj_pxl_t  o;
        c = '{prio: 1'b1, pal: 2'd3, color: 4'h7};
        s = '{prio: 1'b0, pal: 6'h2c, color: 4'h4};
        o = '{prio: 2'd0, pal: 6'h00, color: 4'h0};
        test_name = "video off";
        video_en = 1'b0;
        run_pixel(c, s, s, o);
        test_name = "video on";
        video_en = 1'b1;
        run_pixel(c, s, s, o);
    endtask

    task automatic blanking();
        colmix_pkg::char_pxl_t c;
        colmix_pkg::scr_pxl_t  s;
        colmix_pkg::obj_pxl_t  o;
        c = '{prio: 1'b0, pal: 2'd0, color: 4'h0};
        s = '{prio: 1'b1, pal: 6'h1b, color: 4'hd};
        o = '{prio: 2'd0, pal: 6'h00, color: 4'h0};
        test_name = "hblank";
        lhbl = 1'b0;
        run_pixel(c, s, s, o);
        test_name = "vblank";
        lhbl = 1'b1;
        lvbl = 1'b0;
        run_pixel(c, s, s, o);
        test_name = "active";
        lvbl = 1'b1;
        run_pixel(c, s, s, o);
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        pxl_cen  = 1'b0;
        video_en = 1'b1;
        lhbl     = 1'b1;
        lvbl     = 1'b1;
        gfx_en   = 4'hf;
        cpu      = '0;
        char_pxl = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        obj_pxl  = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        cpu_access();
        layer_priority();
        fall_through();
        shadow_objects();
        video_enable();
        blanking();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/colmix_pkg.sv
logic/layer_mux.sv
logic/palette_ram.sv
logic/shade_blank.sv
logic/colmix_top.sv
verification/tb_colmix.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_colmix
FILELIST = vlog.f
OBJDIR   = obj_dir

SRCS = $(shell cat $(FILELIST))
BIN  = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the output is searched for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
